// ==== Makefile ====
SOURCES := $(wildcard verilog/*.sv) $(wildcard verification/*.sv)

.PHONY: run clean

obj_dir/Vexec_cluster_tb: all.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal --top-module exec_cluster_tb -f all.f

run: obj_dir/Vexec_cluster_tb
	./obj_dir/Vexec_cluster_tb > sim.log 2>&1; cat sim.log
	@! grep -q "test failed" sim.log
	@grep -q "test passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== all.f ====
verilog/exec_pkg.sv
verilog/operand_capture.sv
verilog/rs_slots.sv
verilog/alu_unit.sv
verilog/branch_unit.sv
verilog/cdb_arbiter.sv
verilog/exec_cluster.sv
verification/tb_clock.sv
verification/exec_cluster_tb.sv

// ==== verification/exec_cluster_tb.sv ====
module exec_cluster_tb;

import exec_pkg::*;

localparam int ALU_DEPTH   = 4;
localparam int BR_DEPTH    = 2;
localparam int DRIVE_DELAY = 5;
// Six tests of up to about 300 cycles each
localparam int CYCLE_LIMIT = 2000;

logic clk;
logic rst_n;
logic flush;

logic                            [1:0] dispatch_valid;
fu_sel_t                         [1:0] dispatch_fu;
alu_op_t                         [1:0] dispatch_alu_op;
branch_op_t                      [1:0] dispatch_br_op;
rob_tag_t                        [1:0] dispatch_rob;
logic                            [3:0] src_ready;
rob_tag_t                        [3:0] src_tag;
word_t                           [3:0] src_value;
logic [$clog2(ALU_DEPTH+1)-1:0]        alu_free;
logic [$clog2(BR_DEPTH+1)-1:0]         branch_free;
rob_tag_t                        [3:0] rob_raddr;
logic                            [3:0] rob_rdata_valid;
word_t                           [3:0] rob_rdata;
logic                                  cdb_valid;
rob_tag_t                              cdb_rob;
word_t                                 cdb_value;

// ROB model, entries marked complete by the test
bit    rob_ok  [16];
word_t rob_val [16];

// Expected results and collected broadcasts
bit    exp_live   [rob_tag_t];
bit    exp_branch [rob_tag_t];
word_t exp_value  [rob_tag_t];
int    seen_count [rob_tag_t];
word_t seen_value [rob_tag_t];

string test_name;
int    errors;
int    start_errors;
int    passed;
int    failed;
int    cycles;
int    seed = 32'h3861_024c;

tb_clock #(
	.PERIOD       ( 40 ),
	.RESET_CYCLES ( 10 )
) tb_clock_i (
	.clk_o   ( clk   ),
	.rst_n_o ( rst_n )
);

exec_cluster #(
	.ALU_DEPTH ( ALU_DEPTH ),
	.BR_DEPTH  ( BR_DEPTH  )
) exec_cluster_i (
	.clk_i             ( clk             ),
	.rst_n_i           ( rst_n           ),
	.flush_i           ( flush           ),
	.dispatch_valid_i  ( dispatch_valid  ),
	.dispatch_fu_i     ( dispatch_fu     ),
	.dispatch_alu_op_i ( dispatch_alu_op ),
	.dispatch_br_op_i  ( dispatch_br_op  ),
	.dispatch_rob_i    ( dispatch_rob    ),
	.src_ready_i       ( src_ready       ),
	.src_tag_i         ( src_tag         ),
	.src_value_i       ( src_value       ),
	.alu_free_o        ( alu_free        ),
	.branch_free_o     ( branch_free     ),
	.rob_raddr_o       ( rob_raddr       ),
	.rob_rdata_valid_i ( rob_rdata_valid ),
	.rob_rdata_i       ( rob_rdata       ),
	.cdb_valid_o       ( cdb_valid       ),
	.cdb_rob_o         ( cdb_rob         ),
	.cdb_value_o       ( cdb_value       )
);

always_comb begin
	for (int i = 0; i < 4; i++) begin
		rob_rdata_valid[i] = rob_ok[rob_raddr[i]];
		rob_rdata[i]       = rob_val[rob_raddr[i]];
	end
end

// Bus is registered, so mid-cycle is stable
always @(negedge clk) begin
	if (rst_n && cdb_valid) begin
		if (!exp_live.exists(cdb_rob)) begin
			$display("unexpected CDB broadcast of tag %0d in %s", cdb_rob, test_name);
			errors++;
		end else if (seen_count.exists(cdb_rob)) begin
			seen_count[cdb_rob]++;
		end else begin
			seen_count[cdb_rob] = 1;
			seen_value[cdb_rob] = cdb_value;
		end
	end
end

always @(posedge clk) begin
	cycles++;
	if (cycles >= CYCLE_LIMIT) begin
		$display("timeout after %0d cycles in %s", cycles, test_name);
		$display("test failed");
		$finish;
	end
end

function automatic word_t alu_model(alu_op_t op, word_t a, word_t b);
	logic [4:0] sh;
	sh = b[4:0];
	case (op)
		ADD:     return a + b;
		SUB:     return a + ~b + 32'd1;
		AND:     return a & b;
		OR:      return a | b;
		XOR:     return a ^ b;
		// Sign bits decide unless they agree
		SLT:     return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
		SLL:     return a << sh;
		SRL:     return a >> sh;
		default: return '0;
	endcase
endfunction

function automatic bit branch_model(branch_op_t op, word_t a, word_t b);
	bit less;
	less = (a[31] != b[31]) ? a[31] : (a < b);
	case (op)
		BEQ:     return a == b;
		BNE:     return a != b;
		BLT:     return less;
		BGE:     return !less;
		default: return 1'b0;
	endcase
endfunction

task automatic check_word(rob_tag_t tag, word_t expected, word_t actual);
	if (expected !== actual) begin
		$display("FAIL %s tag %0d expected %h actual %h", test_name, tag, expected, actual);
		errors++;
	end
endtask

task automatic check_taken(rob_tag_t tag, bit expected, bit actual);
	if (expected !== actual) begin
		$display("FAIL %s tag %0d expected taken %0b actual %0b",
			test_name, tag, expected, actual);
		errors++;
	end
endtask

task automatic step();
	@(posedge clk);
	#DRIVE_DELAY;
endtask

task automatic clear_lanes();
	dispatch_valid = '0;
	dispatch_rob   = '0;
	src_ready      = '0;
	src_tag        = '0;
	src_value      = '0;
	for (int l = 0; l < 2; l++) begin
		dispatch_fu[l]     = FU_ALU;
		dispatch_alu_op[l] = ADD;
		dispatch_br_op[l]  = BEQ;
	end
endtask

// Offered lanes are taken at this edge
task automatic clock_in();
	step();
	clear_lanes();
endtask

task automatic wait_slots(int n_alu, int n_br);
	while (alu_free < n_alu || branch_free < n_br) begin
		step();
	end
endtask

task automatic add_expected(rob_tag_t tag, bit is_branch, word_t value);
	exp_live[tag]   = 1'b1;
	exp_branch[tag] = is_branch;
	exp_value[tag]  = value;
endtask

task automatic put_lane(int lane, fu_sel_t fu, alu_op_t aop, branch_op_t bop, rob_tag_t tag,
		bit ready_a, rob_tag_t tag_a, word_t val_a,
		bit ready_b, rob_tag_t tag_b, word_t val_b);
	dispatch_valid[lane]  = 1'b1;
	dispatch_fu[lane]     = fu;
	dispatch_alu_op[lane] = aop;
	dispatch_br_op[lane]  = bop;
	dispatch_rob[lane]    = tag;
	src_ready[2*lane]     = ready_a;
	src_tag[2*lane]       = tag_a;
	src_value[2*lane]     = val_a;
	src_ready[2*lane+1]   = ready_b;
	src_tag[2*lane+1]     = tag_b;
	src_value[2*lane+1]   = val_b;
endtask

task automatic put_alu_ready(int lane, rob_tag_t tag, alu_op_t op, word_t a, word_t b);
	put_lane(lane, FU_ALU, op, BEQ, tag, 1'b1, '0, a, 1'b1, '0, b);
	add_expected(tag, 1'b0, alu_model(op, a, b));
endtask

task automatic put_branch_ready(int lane, rob_tag_t tag, branch_op_t op, word_t a, word_t b);
	put_lane(lane, FU_BRANCH, ADD, op, tag, 1'b1, '0, a, 1'b1, '0, b);
	add_expected(tag, 1'b1, word_t'(branch_model(op, a, b)));
endtask

task automatic start_test(string name);
	test_name = name;
	exp_live.delete();
	exp_branch.delete();
	exp_value.delete();
	seen_count.delete();
	seen_value.delete();
	for (int i = 0; i < 16; i++) begin
		rob_ok[i]  = 1'b0;
		rob_val[i] = '0;
	end
	start_errors = errors;
endtask

function automatic bit all_seen();
	foreach (exp_live[t]) begin
		if (!seen_count.exists(t)) begin
			return 1'b0;
		end
	end
	return 1'b1;
endfunction

// Idle cycles afterwards expose late duplicates
task automatic drain();
	while (!all_seen()) begin
		step();
	end
	repeat (6) step();
endtask

task automatic finish_test();
	foreach (exp_live[t]) begin
		if (!seen_count.exists(t)) begin
			$display("%s: tag %0d never reached the CDB", test_name, t);
			errors++;
		end else if (seen_count[t] > 1) begin
			$display("%s: tag %0d broadcast %0d times", test_name, t, seen_count[t]);
			errors++;
		end else if (exp_branch[t]) begin
			check_taken(t, exp_value[t][0], seen_value[t][0]);
			if (seen_value[t][31:1] != '0) begin
				$display("%s: branch tag %0d has upper result bits set", test_name, t);
				errors++;
			end
		end else begin
			check_word(t, exp_value[t], seen_value[t]);
		end
	end
	if (errors == start_errors) begin
		$display("%s: ok", test_name);
		passed++;
	end else begin
		$display("%s: %0d errors", test_name, errors - start_errors);
		failed++;
	end
endtask

task automatic run_alu_ops();
	word_t a;
	word_t b;
	start_test("alu_ops");
	for (int i = 0; i < 8; i += 2) begin
		wait_slots(2, 0);
		for (int l = 0; l < 2; l++) begin
			a = $random(seed);
			b = $random(seed);
			put_alu_ready(l, rob_tag_t'(i + l), alu_op_t'(i + l), a, b);
		end
		clock_in();
	end
	drain();
	finish_test();
endtask

task automatic run_dependency_chain();
	word_t a;
	word_t b;
	word_t c;
	word_t d;
	start_test("dependency_chain");
	a = $random(seed);
	b = $random(seed);
	c = $random(seed);
	d = $random(seed);
	wait_slots(2, 0);
	put_alu_ready(0, 4'd1, ADD, a, b);
	put_lane(1, FU_ALU, SUB, BEQ, 4'd2, 1'b0, 4'd1, 32'hdead_beef, 1'b1, '0, c);
	add_expected(4'd2, 1'b0, alu_model(SUB, alu_model(ADD, a, b), c));
	clock_in();
	// Third one dispatched while tag 2 is on the bus
	while (!(cdb_valid && cdb_rob == 4'd2)) begin
		step();
	end
	put_lane(0, FU_ALU, XOR, BEQ, 4'd3, 1'b1, '0, d, 1'b0, 4'd2, 32'hdead_beef);
	add_expected(4'd3, 1'b0, alu_model(XOR, d, exp_value[4'd2]));
	clock_in();
	drain();
	finish_test();
endtask

task automatic run_rob_read();
	word_t x;
	word_t y;
	start_test("rob_read");
	x = $random(seed);
	y = $random(seed);
	rob_ok[9]   = 1'b1;
	rob_val[9]  = x;
	rob_ok[10]  = 1'b1;
	rob_val[10] = y;
	rob_ok[11]  = 1'b1;
	rob_val[11] = x;
	wait_slots(1, 1);
	put_lane(0, FU_ALU, ADD, BEQ, 4'd4, 1'b0, 4'd9, 32'hdead_beef, 1'b0, 4'd10, 32'hdead_beef);
	add_expected(4'd4, 1'b0, alu_model(ADD, x, y));
	put_lane(1, FU_BRANCH, ADD, BEQ, 4'd5, 1'b0, 4'd9, '0, 1'b0, 4'd11, 32'h1);
	add_expected(4'd5, 1'b1, word_t'(branch_model(BEQ, x, x)));
	clock_in();
	drain();
	finish_test();
endtask

task automatic run_branches();
	branch_op_t ops [8] = '{BEQ, BEQ, BNE, BNE, BLT, BLT, BGE, BGE};
	word_t      lhs [8] = '{32'd7, 32'd7, 32'd3, -32'sd2, -32'sd5, 32'd3, -32'sd1, -32'sd8};
	word_t      rhs [8] = '{32'd7, 32'd8, 32'd4, -32'sd2, 32'd3, -32'sd5, -32'sd7, 32'd2};
	word_t      a;
	word_t      b;
	start_test("branches");
	for (int i = 0; i < 8; i++) begin
		a = $random(seed);
		b = $random(seed);
		wait_slots(1, 1);
		put_alu_ready(0, rob_tag_t'(2 * i), alu_op_t'(i), a, b);
		put_branch_ready(1, rob_tag_t'(2 * i + 1), ops[i], lhs[i], rhs[i]);
		clock_in();
	end
	drain();
	finish_test();
endtask

task automatic run_backpressure();
	int    n;
	word_t b;
	start_test("backpressure");
	n = 0;
	// Everything waits on branch tag 15, whose taken flag is 1
	while (alu_free != 0 && n < 8) begin
		b = $random(seed);
		put_lane(0, FU_ALU, alu_op_t'(n), BEQ, rob_tag_t'(n), 1'b0, 4'd15, '0, 1'b1, '0, b);
		add_expected(rob_tag_t'(n), 1'b0, alu_model(alu_op_t'(n), 32'd1, b));
		clock_in();
		n++;
	end
	if (n != ALU_DEPTH) begin
		$display("%s: ALU station filled after %0d entries", test_name, n);
		errors++;
	end
	for (int k = 0; k < 3; k++) begin
		put_lane(0, FU_ALU, ADD, BEQ, 4'd14, 1'b1, '0, 32'd1, 1'b1, '0, 32'd1);
		clock_in();
		if (alu_free != 0) begin
			$display("%s: ALU station took an entry while full", test_name);
			errors++;
		end
	end
	wait_slots(0, 1);
	put_branch_ready(0, 4'd15, BEQ, 32'd5, 32'd5);
	clock_in();
	drain();
	if (alu_free != ALU_DEPTH) begin
		$display("%s: ALU station not empty after drain", test_name);
		errors++;
	end
	finish_test();
endtask

task automatic run_flush();
	word_t a;
	word_t b;
	start_test("flush");
	a = $random(seed);
	b = $random(seed);
	wait_slots(2, 1);
	put_lane(0, FU_ALU, ADD, BEQ, 4'd0, 1'b0, 4'd12, '0, 1'b1, '0, 32'd3);
	put_lane(1, FU_ALU, SUB, BEQ, 4'd1, 1'b0, 4'd12, '0, 1'b0, 4'd12, '0);
	clock_in();
	put_lane(0, FU_ALU, OR, BEQ, 4'd2, 1'b1, '0, 32'd5, 1'b0, 4'd12, '0);
	put_lane(1, FU_BRANCH, ADD, BNE, 4'd3, 1'b0, 4'd12, '0, 1'b1, '0, '0);
	clock_in();
	if (alu_free != 1 || branch_free != 1) begin
		$display("%s: stations hold the wrong number of waiting entries", test_name);
		errors++;
	end
	flush = 1'b1;
	step();
	flush = 1'b0;
	if (alu_free != ALU_DEPTH || branch_free != BR_DEPTH) begin
		$display("%s: stations not empty after flush", test_name);
		errors++;
	end
	put_alu_ready(0, 4'd5, SLL, a, b);
	put_branch_ready(1, 4'd6, BGE, b, a);
	clock_in();
	drain();
	finish_test();
endtask

initial begin
	test_name = "reset";
	errors    = 0;
	passed    = 0;
	failed    = 0;
	cycles    = 0;
	flush     = 1'b0;
	clear_lanes();
	@(posedge rst_n);
	step();
	run_alu_ops();
	run_dependency_chain();
	run_rob_read();
	run_branches();
	run_backpressure();
	run_flush();
	$display("summary: %0d ok, %0d failing", passed, failed);
	if (failed == 0 && errors == 0) begin
		$display("test passed");
	end else begin
		$display("test failed");
	end
	$finish;
end

endmodule

// ==== verification/tb_clock.sv ====
module tb_clock #(
	parameter int PERIOD       = 40,
	parameter int RESET_CYCLES = 10
)(
	output logic clk_o,
	output logic rst_n_o
);

initial begin
	clk_o = 1'b0;
	forever #(PERIOD / 2) clk_o = ~clk_o;
end

// Release shortly after the last reset edge
initial begin
	rst_n_o = 1'b0;
	repeat (RESET_CYCLES) @(posedge clk_o);
	#1 rst_n_o = 1'b1;
end

endmodule

// ==== verilog/alu_unit.sv ====
module alu_unit #(
	parameter int DEPTH = 4
)(
	input  logic                         clk_i,
	input  logic                         rst_n_i,
	input  logic                         flush_i,

	input  logic                   [1:0] valid_i,
	input  exec_pkg::fu_sel_t      [1:0] fu_i,
	input  exec_pkg::alu_op_t      [1:0] alu_op_i,
	input  exec_pkg::rob_tag_t     [1:0] rob_i,
	input  logic                   [3:0] op_ready_i,
	input  exec_pkg::rob_tag_t     [3:0] op_tag_i,
	input  exec_pkg::word_t        [3:0] op_value_i,

	input  logic                         cdb_valid_i,
	input  exec_pkg::rob_tag_t           cdb_rob_i,
	input  exec_pkg::word_t              cdb_value_i,

	input  logic                         grant_i,
	output logic [$clog2(DEPTH+1)-1:0]   free_o,
	output logic                         done_o,
	output exec_pkg::rob_tag_t           done_rob_o,
	output exec_pkg::word_t              done_value_o
);

import exec_pkg::*;

logic [1:0] write;
logic       issue_valid;
logic       issue_ready;
alu_op_t    issue_op;
rob_tag_t   issue_rob;
word_t      opa;
word_t      opb;
word_t      result;

always_comb begin
	for (int l = 0; l < 2; l++) begin
		write[l] = valid_i[l] && (fu_i[l] == FU_ALU);
	end
end

rs_slots #(
	.DEPTH     ( DEPTH    ),
	.payload_t ( alu_op_t )
) alu_rs_i (
	.clk_i,
	.rst_n_i,
	.flush_i,
	.write_i         ( write       ),
	.write_payload_i ( alu_op_i    ),
	.write_rob_i     ( rob_i       ),
	.write_ready_i   ( op_ready_i  ),
	.write_tag_i     ( op_tag_i    ),
	.write_value_i   ( op_value_i  ),
	.cdb_valid_i,
	.cdb_rob_i,
	.cdb_value_i,
	.issue_ready_i   ( issue_ready ),
	.free_o,
	.issue_valid_o   ( issue_valid ),
	.issue_payload_o ( issue_op    ),
	.issue_rob_o     ( issue_rob   ),
	.issue_a_o       ( opa         ),
	.issue_b_o       ( opb         )
);

// Register frees up on the cycle it is granted
assign issue_ready = !done_o || grant_i;

always_comb begin
	case (issue_op)
		ADD:     result = opa + opb;
		SUB:     result = opa - opb;
		AND:     result = opa & opb;
		OR:      result = opa | opb;
		XOR:     result = opa ^ opb;
		SLT:     result = word_t'($signed(opa) < $signed(opb));
		SLL:     result = opa << opb[4:0];
		SRL:     result = opa >> opb[4:0];
		default: result = '0;
	endcase
end

always_ff @(posedge clk_i or negedge rst_n_i) begin
	if (!rst_n_i) begin
		done_o <= 1'b0;
	end else if (flush_i) begin
		done_o <= 1'b0;
	end else if (issue_valid && issue_ready) begin
		done_o <= 1'b1;
	end else if (grant_i) begin
		done_o <= 1'b0;
	end
end

always_ff @(posedge clk_i) begin
	if (issue_valid && issue_ready) begin
		done_rob_o   <= issue_rob;
		done_value_o <= result;
	end
end

endmodule

// ==== verilog/branch_unit.sv ====
module branch_unit #(
	parameter int DEPTH = 2
)(
	input  logic                         clk_i,
	input  logic                         rst_n_i,
	input  logic                         flush_i,

	input  logic                   [1:0] valid_i,
	input  exec_pkg::fu_sel_t      [1:0] fu_i,
	input  exec_pkg::branch_op_t   [1:0] br_op_i,
	input  exec_pkg::rob_tag_t     [1:0] rob_i,
	input  logic                   [3:0] op_ready_i,
	input  exec_pkg::rob_tag_t     [3:0] op_tag_i,
	input  exec_pkg::word_t        [3:0] op_value_i,

	input  logic                         cdb_valid_i,
	input  exec_pkg::rob_tag_t           cdb_rob_i,
	input  exec_pkg::word_t              cdb_value_i,

	input  logic                         grant_i,
	output logic [$clog2(DEPTH+1)-1:0]   free_o,
	output logic                         done_o,
	output exec_pkg::rob_tag_t           done_rob_o,
	output exec_pkg::word_t              done_value_o
);

import exec_pkg::*;

logic [1:0] write;
logic       issue_valid;
logic       issue_ready;
branch_op_t issue_op;
rob_tag_t   issue_rob;
word_t      opa;
word_t      opb;
logic       taken;

always_comb begin
	for (int l = 0; l < 2; l++) begin
		write[l] = valid_i[l] && (fu_i[l] == FU_BRANCH);
	end
end

rs_slots #(
	.DEPTH     ( DEPTH       ),
	.payload_t ( branch_op_t )
) branch_rs_i (
	.clk_i,
	.rst_n_i,
	.flush_i,
	.write_i         ( write       ),
	.write_payload_i ( br_op_i     ),
	.write_rob_i     ( rob_i       ),
	.write_ready_i   ( op_ready_i  ),
	.write_tag_i     ( op_tag_i    ),
	.write_value_i   ( op_value_i  ),
	.cdb_valid_i,
	.cdb_rob_i,
	.cdb_value_i,
	.issue_ready_i   ( issue_ready ),
	.free_o,
	.issue_valid_o   ( issue_valid ),
	.issue_payload_o ( issue_op    ),
	.issue_rob_o     ( issue_rob   ),
	.issue_a_o       ( opa         ),
	.issue_b_o       ( opb         )
);

assign issue_ready = !done_o || grant_i;

always_comb begin
	case (issue_op)
		BEQ:     taken = (opa == opb);
		BNE:     taken = (opa != opb);
		BLT:     taken = $signed(opa) < $signed(opb);
		BGE:     taken = $signed(opa) >= $signed(opb);
		default: taken = 1'b0;
	endcase
end

always_ff @(posedge clk_i or negedge rst_n_i) begin
	if (!rst_n_i) begin
		done_o <= 1'b0;
	end else if (flush_i) begin
		done_o <= 1'b0;
	end else if (issue_valid && issue_ready) begin
		done_o <= 1'b1;
	end else if (grant_i) begin
		done_o <= 1'b0;
	end
end

// Taken flag in bit 0 only
always_ff @(posedge clk_i) begin
	if (issue_valid && issue_ready) begin
		done_rob_o   <= issue_rob;
		done_value_o <= word_t'(taken);
	end
end

endmodule

// ==== verilog/cdb_arbiter.sv ====
module cdb_arbiter(
	input  logic                clk_i,
	input  logic                rst_n_i,
	input  logic                flush_i,

	input  logic                alu_done_i,
	input  exec_pkg::rob_tag_t  alu_rob_i,
	input  exec_pkg::word_t     alu_value_i,
	input  logic                br_done_i,
	input  exec_pkg::rob_tag_t  br_rob_i,
	input  exec_pkg::word_t     br_value_i,

	output logic                alu_grant_o,
	output logic                br_grant_o,
	output logic                cdb_valid_o,
	output exec_pkg::rob_tag_t  cdb_rob_o,
	output exec_pkg::word_t     cdb_value_o
);

// ALU wins, branch waits
assign alu_grant_o = alu_done_i;
assign br_grant_o  = br_done_i && !alu_done_i;

always_ff @(posedge clk_i or negedge rst_n_i) begin
	if (!rst_n_i) begin
		cdb_valid_o <= 1'b0;
	end else if (flush_i) begin
		cdb_valid_o <= 1'b0;
	end else begin
		cdb_valid_o <= alu_done_i || br_done_i;
	end
end

always_ff @(posedge clk_i) begin
	if (alu_grant_o) begin
		cdb_rob_o   <= alu_rob_i;
		cdb_value_o <= alu_value_i;
	end else if (br_grant_o) begin
		cdb_rob_o   <= br_rob_i;
		cdb_value_o <= br_value_i;
	end
end

assert property (@(posedge clk_i) disable iff (!rst_n_i)
	!(alu_grant_o && br_grant_o));

endmodule

// ==== verilog/exec_cluster.sv ====
module exec_cluster #(
	parameter int ALU_DEPTH = 4,
	parameter int BR_DEPTH  = 2
)(
	input  logic                             clk_i,
	input  logic                             rst_n_i,
	input  logic                             flush_i,

	// Dispatch lanes
	input  logic                       [1:0] dispatch_valid_i,
	input  exec_pkg::fu_sel_t          [1:0] dispatch_fu_i,
	input  exec_pkg::alu_op_t          [1:0] dispatch_alu_op_i,
	input  exec_pkg::branch_op_t       [1:0] dispatch_br_op_i,
	input  exec_pkg::rob_tag_t         [1:0] dispatch_rob_i,
	input  logic                       [3:0] src_ready_i,
	input  exec_pkg::rob_tag_t         [3:0] src_tag_i,
	input  exec_pkg::word_t            [3:0] src_value_i,
	output logic [$clog2(ALU_DEPTH+1)-1:0]   alu_free_o,
	output logic [$clog2(BR_DEPTH+1)-1:0]    branch_free_o,

	// ROB read
	output exec_pkg::rob_tag_t         [3:0] rob_raddr_o,
	input  logic                       [3:0] rob_rdata_valid_i,
	input  exec_pkg::word_t            [3:0] rob_rdata_i,

	// CDB
	output logic                             cdb_valid_o,
	output exec_pkg::rob_tag_t               cdb_rob_o,
	output exec_pkg::word_t                  cdb_value_o
);

import exec_pkg::*;

logic     [3:0] op_ready;
rob_tag_t [3:0] op_tag;
word_t    [3:0] op_value;

logic     alu_done;
rob_tag_t alu_rob;
word_t    alu_value;
logic     alu_grant;
logic     br_done;
rob_tag_t br_rob;
word_t    br_value;
logic     br_grant;

operand_capture operand_capture_i(
	.src_ready_i,
	.src_tag_i,
	.src_value_i,
	.rob_raddr_o,
	.rob_rdata_valid_i,
	.rob_rdata_i,
	.cdb_valid_i ( cdb_valid_o ),
	.cdb_rob_i   ( cdb_rob_o   ),
	.cdb_value_i ( cdb_value_o ),
	.op_ready_o  ( op_ready    ),
	.op_tag_o    ( op_tag      ),
	.op_value_o  ( op_value    )
);

alu_unit #(
	.DEPTH ( ALU_DEPTH )
) alu_unit_i (
	.clk_i,
	.rst_n_i,
	.flush_i,
	.valid_i      ( dispatch_valid_i  ),
	.fu_i         ( dispatch_fu_i     ),
	.alu_op_i     ( dispatch_alu_op_i ),
	.rob_i        ( dispatch_rob_i    ),
	.op_ready_i   ( op_ready          ),
	.op_tag_i     ( op_tag            ),
	.op_value_i   ( op_value          ),
	.cdb_valid_i  ( cdb_valid_o       ),
	.cdb_rob_i    ( cdb_rob_o         ),
	.cdb_value_i  ( cdb_value_o       ),
	.grant_i      ( alu_grant         ),
	.free_o       ( alu_free_o        ),
	.done_o       ( alu_done          ),
	.done_rob_o   ( alu_rob           ),
	.done_value_o ( alu_value         )
);

branch_unit #(
	.DEPTH ( BR_DEPTH )
) branch_unit_i (
	.clk_i,
	.rst_n_i,
	.flush_i,
	.valid_i      ( dispatch_valid_i ),
	.fu_i         ( dispatch_fu_i    ),
	.br_op_i      ( dispatch_br_op_i ),
	.rob_i        ( dispatch_rob_i   ),
	.op_ready_i   ( op_ready         ),
	.op_tag_i     ( op_tag           ),
	.op_value_i   ( op_value         ),
	.cdb_valid_i  ( cdb_valid_o      ),
	.cdb_rob_i    ( cdb_rob_o        ),
	.cdb_value_i  ( cdb_value_o      ),
	.grant_i      ( br_grant         ),
	.free_o       ( branch_free_o    ),
	.done_o       ( br_done          ),
	.done_rob_o   ( br_rob           ),
	.done_value_o ( br_value         )
);

cdb_arbiter cdb_arbiter_i(
	.clk_i,
	.rst_n_i,
	.flush_i,
	.alu_done_i  ( alu_done  ),
	.alu_rob_i   ( alu_rob   ),
	.alu_value_i ( alu_value ),
	.br_done_i   ( br_done   ),
	.br_rob_i    ( br_rob    ),
	.br_value_i  ( br_value  ),
	.alu_grant_o ( alu_grant ),
	.br_grant_o  ( br_grant  ),
	.cdb_valid_o,
	.cdb_rob_o,
	.cdb_value_o
);

endmodule

// ==== verilog/exec_pkg.sv ====
package exec_pkg;

	localparam int ROB_IDX_W = 4;
	localparam int WORD_W    = 32;

	// Reorder buffer index, 16 instructions in flight
	typedef logic [ROB_IDX_W-1:0] rob_tag_t;

	typedef logic [WORD_W-1:0] word_t;

	// Target station of a dispatched instruction
	typedef enum logic {
		FU_ALU    = 1'b0,
		FU_BRANCH = 1'b1
	} fu_sel_t;

	// SLT is signed, shifts use the low 5 bits of operand b
	typedef enum logic [2:0] {
		ADD = 3'd0,
		SUB = 3'd1,
		AND = 3'd2,
		OR  = 3'd3,
		XOR = 3'd4,
		SLT = 3'd5,
		SLL = 3'd6,
		SRL = 3'd7
	} alu_op_t;

	// BLT and BGE compare as signed
	typedef enum logic [1:0] {
		BEQ = 2'd0,
		BNE = 2'd1,
		BLT = 2'd2,
		BGE = 2'd3
	} branch_op_t;

endpackage

// ==== verilog/operand_capture.sv ====
module operand_capture(
	// Source operands, index 2*lane+source
	input  logic                     [3:0] src_ready_i,
	input  exec_pkg::rob_tag_t       [3:0] src_tag_i,
	input  exec_pkg::word_t          [3:0] src_value_i,

	// ROB read port
	output exec_pkg::rob_tag_t       [3:0] rob_raddr_o,
	input  logic                     [3:0] rob_rdata_valid_i,
	input  exec_pkg::word_t          [3:0] rob_rdata_i,

	// CDB
	input  logic                           cdb_valid_i,
	input  exec_pkg::rob_tag_t             cdb_rob_i,
	input  exec_pkg::word_t                cdb_value_i,

	// Merged operands to the stations
	output logic                     [3:0] op_ready_o,
	output exec_pkg::rob_tag_t       [3:0] op_tag_o,
	output exec_pkg::word_t          [3:0] op_value_o
);

logic [3:0] cdb_hit;

assign rob_raddr_o = src_tag_i;
assign op_tag_o    = src_tag_i;

always_comb begin
	for (int i = 0; i < 4; i++) begin
		cdb_hit[i] = cdb_valid_i && (cdb_rob_i == src_tag_i[i]);
	end
end

// Priority: already ready, then ROB, then same-cycle CDB bypass
always_comb begin
	for (int i = 0; i < 4; i++) begin
		op_ready_o[i] = 1'b1;
		if (src_ready_i[i]) begin
			op_value_o[i] = src_value_i[i];
		end else if (rob_rdata_valid_i[i]) begin
			op_value_o[i] = rob_rdata_i[i];
		end else if (cdb_hit[i]) begin
			op_value_o[i] = cdb_value_i;
		end else begin
			// Left to the station wakeup
			op_ready_o[i] = 1'b0;
			op_value_o[i] = src_value_i[i];
		end
	end
end

endmodule

// ==== verilog/rs_slots.sv ====
module rs_slots #(
	parameter int  DEPTH     = 4,
	parameter type payload_t = logic [2:0]
)(
	input  logic                         clk_i,
	input  logic                         rst_n_i,
	input  logic                         flush_i,

	// Two write lanes, operands at 2*lane+source
	input  logic                   [1:0] write_i,
	input  payload_t               [1:0] write_payload_i,
	input  exec_pkg::rob_tag_t     [1:0] write_rob_i,
	input  logic                   [3:0] write_ready_i,
	input  exec_pkg::rob_tag_t     [3:0] write_tag_i,
	input  exec_pkg::word_t        [3:0] write_value_i,

	input  logic                         cdb_valid_i,
	input  exec_pkg::rob_tag_t           cdb_rob_i,
	input  exec_pkg::word_t              cdb_value_i,

	input  logic                         issue_ready_i,
	output logic [$clog2(DEPTH+1)-1:0]   free_o,
	output logic                         issue_valid_o,
	output payload_t                     issue_payload_o,
	output exec_pkg::rob_tag_t           issue_rob_o,
	output exec_pkg::word_t              issue_a_o,
	output exec_pkg::word_t              issue_b_o
);

import exec_pkg::*;

localparam int CNT_W = $clog2(DEPTH + 1);
localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

logic     [DEPTH-1:0] slot_valid;
logic     [DEPTH-1:0] slot_rdy_a;
logic     [DEPTH-1:0] slot_rdy_b;
payload_t             slot_payload [DEPTH];
rob_tag_t             slot_rob     [DEPTH];
rob_tag_t             slot_tag_a   [DEPTH];
rob_tag_t             slot_tag_b   [DEPTH];
word_t                slot_val_a   [DEPTH];
word_t                slot_val_b   [DEPTH];
// Rank among occupied slots, 0 is the oldest
logic [IDX_W-1:0]     slot_age     [DEPTH];

logic [CNT_W-1:0] used_cnt;
logic [CNT_W-1:0] keep_cnt;
logic [1:0]       wr_en;
logic [IDX_W-1:0] wr_slot [2];
logic [IDX_W-1:0] lane_age [2];
logic             sel_found;
logic [IDX_W-1:0] sel_idx;
logic [IDX_W-1:0] sel_age;
logic             issue_fire;

always_comb begin
	used_cnt = '0;
	for (int i = 0; i < DEPTH; i++) begin
		used_cnt = used_cnt + CNT_W'(slot_valid[i]);
	end
end

assign free_o = CNT_W'(DEPTH) - used_cnt;

// Lane 0 takes the first free slot, lane 1 the next one
always_comb begin
	wr_en      = '0;
	wr_slot[0] = '0;
	wr_slot[1] = '0;
	for (int i = 0; i < DEPTH; i++) begin
		if (write_i[0] && !flush_i && !slot_valid[i] && !wr_en[0]) begin
			wr_en[0]   = 1'b1;
			wr_slot[0] = IDX_W'(i);
		end
	end
	for (int i = 0; i < DEPTH; i++) begin
		if (write_i[1] && !flush_i && !slot_valid[i] && !wr_en[1]
				&& !(wr_en[0] && wr_slot[0] == IDX_W'(i))) begin
			wr_en[1]   = 1'b1;
			wr_slot[1] = IDX_W'(i);
		end
	end
end

// Oldest entry with both operands present
always_comb begin
	sel_found = 1'b0;
	sel_idx   = '0;
	sel_age   = '0;
	for (int i = 0; i < DEPTH; i++) begin
		if (slot_valid[i] && slot_rdy_a[i] && slot_rdy_b[i]
				&& (!sel_found || slot_age[i] < sel_age)) begin
			sel_found = 1'b1;
			sel_idx   = IDX_W'(i);
			sel_age   = slot_age[i];
		end
	end
end

assign issue_valid_o   = sel_found;
assign issue_payload_o = slot_payload[sel_idx];
assign issue_rob_o     = slot_rob[sel_idx];
assign issue_a_o       = slot_val_a[sel_idx];
assign issue_b_o       = slot_val_b[sel_idx];
assign issue_fire      = sel_found && issue_ready_i;

// New entries rank behind everything that stays
assign keep_cnt    = used_cnt - CNT_W'(issue_fire);
assign lane_age[0] = IDX_W'(keep_cnt);
assign lane_age[1] = IDX_W'(keep_cnt + CNT_W'(wr_en[0]));

always_ff @(posedge clk_i or negedge rst_n_i) begin
	if (!rst_n_i) begin
		slot_valid <= '0;
		slot_rdy_a <= '0;
		slot_rdy_b <= '0;
		for (int i = 0; i < DEPTH; i++) begin
			slot_age[i] <= '0;
		end
	end else if (flush_i) begin
		slot_valid <= '0;
	end else begin
		for (int i = 0; i < DEPTH; i++) begin
			if (cdb_valid_i && slot_tag_a[i] == cdb_rob_i) begin
				slot_rdy_a[i] <= 1'b1;
			end
			if (cdb_valid_i && slot_tag_b[i] == cdb_rob_i) begin
				slot_rdy_b[i] <= 1'b1;
			end
			if (issue_fire && slot_age[i] > sel_age) begin
				slot_age[i] <= slot_age[i] - 1'b1;
			end
		end
		if (issue_fire) begin
			slot_valid[sel_idx] <= 1'b0;
		end
		for (int l = 0; l < 2; l++) begin
			if (wr_en[l]) begin
				slot_valid[wr_slot[l]] <= 1'b1;
				slot_rdy_a[wr_slot[l]] <= write_ready_i[2*l];
				slot_rdy_b[wr_slot[l]] <= write_ready_i[2*l+1];
				slot_age[wr_slot[l]]   <= lane_age[l];
			end
		end
	end
end

always_ff @(posedge clk_i) begin
	for (int i = 0; i < DEPTH; i++) begin
		if (cdb_valid_i && !slot_rdy_a[i] && slot_tag_a[i] == cdb_rob_i) begin
			slot_val_a[i] <= cdb_value_i;
		end
		if (cdb_valid_i && !slot_rdy_b[i] && slot_tag_b[i] == cdb_rob_i) begin
			slot_val_b[i] <= cdb_value_i;
		end
	end
	for (int l = 0; l < 2; l++) begin
		if (wr_en[l]) begin
			slot_payload[wr_slot[l]] <= write_payload_i[l];
			slot_rob[wr_slot[l]]     <= write_rob_i[l];
			slot_tag_a[wr_slot[l]]   <= write_tag_i[2*l];
			slot_tag_b[wr_slot[l]]   <= write_tag_i[2*l+1];
			slot_val_a[wr_slot[l]]   <= write_value_i[2*l];
			slot_val_b[wr_slot[l]]   <= write_value_i[2*l+1];
		end
	end
end

// Both lanes land in distinct, previously empty slots
assert property (@(posedge clk_i) disable iff (!rst_n_i)
	(!wr_en[0] || !slot_valid[wr_slot[0]]) && (!wr_en[1] || !slot_valid[wr_slot[1]])
	&& !(wr_en[0] && wr_en[1] && wr_slot[0] == wr_slot[1]));

// Issued slot was occupied and fully woken
assert property (@(posedge clk_i) disable iff (!rst_n_i)
	issue_fire |-> slot_valid[sel_idx] && slot_rdy_a[sel_idx] && slot_rdy_b[sel_idx]);

endmodule
